/* filelist.f */
+incdir+logic
logic/instrPkg.sv
logic/pipeCtrlPkg.sv
logic/stageIf.sv
logic/instrClassifier.sv
logic/tuseTnewTable.sv
logic/stageTracker.sv
logic/pipelineControl.sv
logic/pipeCtrlTop.sv
verif/pipeCtrlTb.sv

/* verif/pipeCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module pipeCtrlTb;
    import pipeCtrlPkg::*;

    localparam int NUM_ROWS    = 22;
    localparam int RESET_CYC   = 4;
    localparam int CYCLE_LIMIT = NUM_ROWS + RESET_CYC + 20;
    localparam logic [31:0] IF_PC = 32'h0000_0200;  // fetch PC held constant

    // MIPS major opcodes and SPECIAL funct codes
    localparam logic [5:0] OP_LW   = 6'h23;
    localparam logic [5:0] OP_SW   = 6'h2b;
    localparam logic [5:0] OP_ORI  = 6'h0d;
    localparam logic [5:0] OP_BEQ  = 6'h04;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [31:0] NOP    = 32'h0;

    typedef struct packed {
        logic [3:0]            behavior;
        logic [31:0]           instr;
        logic [31:0]           pc;
        logic [`WIDTH_EXC-1:0] exc;
        kctrlT                 kctrl;
        logic                  mdBusy;
        logic                  expStall;
        logic                  expClrEx;
        logic                  expClrMem;
        logic [`WIDTH_T-1:0]   expTnew;
        logic [31:0]           expMacroPc;
    } rowT;

    logic                  clk;
    logic                  rstN;
    logic [31:0]           instrId;
    logic [31:0]           pcIf;
    logic [31:0]           pcId;
    logic [`WIDTH_EXC-1:0] excId;
    kctrlT                 kctrl;
    logic                  mdBusy;
    logic                  stallPc;
    logic                  stallId;
    logic                  clrId;
    logic                  clrEx;
    logic                  clrMem;
    logic                  clrWb;
    logic                  disMultDiv;
    logic                  disDm;
    logic [31:0]           macroPc;
    logic [`WIDTH_T-1:0]   tnewId;

    rowT stimTable [NUM_ROWS];
    int  rowTotal   = 0;
    int  rowErrors  = 0;
    int  errTotal   = 0;
    int  failedRows = 0;
    int  cycleCount = 0;

    pipeCtrlTop u_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrId    (instrId),
        .pcIf       (pcIf),
        .pcId       (pcId),
        .excId      (excId),
        .kctrl      (kctrl),
        .mdBusy     (mdBusy),
        .stallPc    (stallPc),
        .stallId    (stallId),
        .clrId      (clrId),
        .clrEx      (clrEx),
        .clrMem     (clrMem),
        .clrWb      (clrWb),
        .disMultDiv (disMultDiv),
        .disDm      (disDm),
        .macroPc    (macroPc),
        .tnewId     (tnewId)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addRow(input logic [3:0] beh, input logic [31:0] instr,
                          input logic [31:0] pc, input logic [`WIDTH_EXC-1:0] exc,
                          input kctrlT k, input logic md, input logic eStall,
                          input logic eClrEx, input logic eClrMem,
                          input logic [`WIDTH_T-1:0] eTnew, input logic [31:0] eMacro);
        rowT r;
        r.behavior   = beh;
        r.instr      = instr;
        r.pc         = pc;
        r.exc        = exc;
        r.kctrl      = k;
        r.mdBusy     = md;
        r.expStall   = eStall;
        r.expClrEx   = eClrEx;
        r.expClrMem  = eClrMem;
        r.expTnew    = eTnew;
        r.expMacroPc = eMacro;
        stimTable[rowTotal] = r;
        rowTotal = rowTotal + 1;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            rowErrors = rowErrors + 1;
        end
    endtask

    // pcIf stays at IF_PC throughout
    task automatic buildTable;
        addRow(0, NOP, 32'h0, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 0, IF_PC);  // idle after reset
        // load-use costs one bubble
        addRow(1, iType(OP_LW, 5'd1, 5'd8, 16'h0), 32'h100, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 3, 32'h100);
        addRow(1, rType(5'd8, 5'd2, 5'd9, FN_ADDU), 32'h104, 5'd0, KCTRL_NONE, 0,
               1, 1, 0, 2, 32'h100);
        addRow(1, rType(5'd8, 5'd2, 5'd9, FN_ADDU), 32'h104, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 2, 32'h100);
        // forwarding covers these; MEM holds the bubble in the first row
        addRow(2, rType(5'd9, 5'd9, 5'd10, FN_ADDU), 32'h108, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 2, 32'h104);
        addRow(2, iType(OP_LW, 5'd3, 5'd0, 16'h4), 32'h10c, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 3, 32'h104);
        addRow(2, rType(5'd0, 5'd0, 5'd12, FN_ADDU), 32'h110, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 2, 32'h108);
        addRow(2, iType(OP_LW, 5'd4, 5'd13, 16'h8), 32'h114, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 3, 32'h10c);
        addRow(2, iType(OP_SW, 5'd5, 5'd13, 16'h0), 32'h118, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 0, 32'h110);
        // branch compares in ID
        addRow(3, iType(OP_ORI, 5'd6, 5'd14, 16'h55), 32'h11c, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 2, 32'h114);
        addRow(3, iType(OP_BEQ, 5'd14, 5'd7, 16'h3), 32'h120, 5'd0, KCTRL_NONE, 0,
               1, 1, 0, 0, 32'h118);
        addRow(3, iType(OP_BEQ, 5'd14, 5'd7, 16'h3), 32'h120, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 0, 32'h11c);
        // mult/div unit busy
        addRow(4, rType(5'd0, 5'd0, 5'd15, FN_MFLO), 32'h124, 5'd0, KCTRL_NONE, 1,
               1, 1, 0, 2, 32'h120);
        addRow(4, rType(5'd0, 5'd0, 5'd15, FN_MFLO), 32'h124, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 2, 32'h120);
        addRow(4, rType(5'd1, 5'd2, 5'd16, FN_ADDU), 32'h128, 5'd0, KCTRL_NONE, 1,
               0, 0, 0, 2, 32'h124);
        // exception entry beats the pending load-use stall
        addRow(5, iType(OP_LW, 5'd1, 5'd17, 16'h0), 32'h12c, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 3, 32'h124);
        addRow(5, rType(5'd17, 5'd0, 5'd18, FN_ADDU), 32'h130, 5'd0, KCTRL_KTEXT, 0,
               0, 1, 1, 2, 32'h128);
        addRow(5, rType(5'd17, 5'd0, 5'd18, FN_ADDU), 32'h130, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 2, 32'h130);
        // exception code with a zero PC still counts
        addRow(6, NOP, 32'h0, 5'd4, KCTRL_NONE, 0,
               0, 0, 0, 0, 32'h130);
        addRow(6, NOP, 32'h0, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 0, 32'h130);
        addRow(6, NOP, 32'h0, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 0, 32'h0);   // MEM has exc only
        addRow(6, NOP, 32'h0, 5'd0, KCTRL_NONE, 0,
               0, 0, 0, 0, IF_PC);
    endtask

    initial begin
        rowT r;
        rstN    = 1'b0;
        instrId = NOP;
        pcIf    = IF_PC;
        pcId    = 32'h0;
        excId   = '0;
        kctrl   = KCTRL_NONE;
        mdBusy  = 1'b0;
        buildTable();

        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int i = 0; i < rowTotal; i++) begin
            r = stimTable[i];
            instrId = r.instr;   // falling edge here
            pcId    = r.pc;
            excId   = r.exc;
            kctrl   = r.kctrl;
            mdBusy  = r.mdBusy;
            rowErrors = 0;
            #4;   // 1 ns before the rising edge
            checkValue("stallPc", stallPc, r.expStall);
            checkValue("stallId", stallId, r.expStall);
            checkValue("clrEx", clrEx, r.expClrEx);
            checkValue("clrMem", clrMem, r.expClrMem);
            // the rest of the flush group moves with clrMem
            checkValue("clrId", clrId, r.expClrMem);
            checkValue("clrWb", clrWb, r.expClrMem);
            checkValue("disMultDiv", disMultDiv, r.expClrMem);
            checkValue("disDm", disDm, r.expClrMem);
            checkValue("tnewId", tnewId, r.expTnew);
            checkValue("macroPc", macroPc, r.expMacroPc);
            if (rowErrors != 0) begin
                failedRows = failedRows + 1;
            end
            errTotal = errTotal + rowErrors;
            $display("test %0d (behavior %0d): %s", i, r.behavior,
                     (rowErrors == 0) ? "ok" : "errors");
            @(negedge clk);
        end

        $display("%0d tests run, %0d failed, %0d check errors", rowTotal, failedRows, errTotal);
        if (errTotal == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/pipeCtrlTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module pipeCtrlTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`WIDTH_INSTR-1:0] instrId,
    input  logic [31:0]             pcIf,
    input  logic [31:0]             pcId,
    input  logic [`WIDTH_EXC-1:0]   excId,
    input  pipeCtrlPkg::kctrlT      kctrl,
    input  logic                    mdBusy,
    output logic                    stallPc,
    output logic                    stallId,
    output logic                    clrId,
    output logic                    clrEx,
    output logic                    clrMem,
    output logic                    clrWb,
    output logic                    disMultDiv,
    output logic                    disDm,
    output logic [31:0]             macroPc,
    output logic [`WIDTH_T-1:0]     tnewId
);
    import instrPkg::*;

    opcodeT                opcode;
    funcT                  funcId;
    logic [`WIDTH_REG-1:0] addrRs;
    logic [`WIDTH_REG-1:0] addrRt;
    logic [`WIDTH_REG-1:0] destId;
    logic [`WIDTH_T-1:0]   tuseRs;
    logic [`WIDTH_T-1:0]   tuseRt;

    stageIf stages ();

    instrClassifier uClassifier (
        .instr   (instrId),
        .opcode  (opcode),
        .func    (funcId),
        .addrRs  (addrRs),
        .addrRt  (addrRt),
        .destReg (destId)
    );

    tuseTnewTable uTable (
        .opcode (opcode),
        .func   (funcId),
        .tuseRs (tuseRs),
        .tuseRt (tuseRt),
        .tnewId (tnewId)
    );

    // clear outputs feed back into the stage registers
    stageTracker uTracker (
        .clk    (clk),
        .rstN   (rstN),
        .destId (destId),
        .tnewId (tnewId),
        .pcId   (pcId),
        .excId  (excId),
        .clrEx  (clrEx),
        .clrMem (clrMem),
        .stages (stages.track)
    );

    pipelineControl uControl (
        .addrRs     (addrRs),
        .addrRt     (addrRt),
        .tuseRs     (tuseRs),
        .tuseRt     (tuseRt),
        .funcId     (funcId),
        .mdBusy     (mdBusy),
        .kctrl      (kctrl),
        .pcIf       (pcIf),
        .pcId       (pcId),
        .excId      (excId),
        .stages     (stages.ctrl),
        .stallPc    (stallPc),
        .stallId    (stallId),
        .clrId      (clrId),
        .clrEx      (clrEx),
        .clrMem     (clrMem),
        .clrWb      (clrWb),
        .disMultDiv (disMultDiv),
        .disDm      (disDm),
        .macroPc    (macroPc)
    );

endmodule

`default_nettype wire

/* logic/pipelineControl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module pipelineControl (
    input  logic [`WIDTH_REG-1:0] addrRs,
    input  logic [`WIDTH_REG-1:0] addrRt,
    input  logic [`WIDTH_T-1:0]   tuseRs,
    input  logic [`WIDTH_T-1:0]   tuseRt,
    input  instrPkg::funcT        funcId,
    input  logic                  mdBusy,
    input  pipeCtrlPkg::kctrlT    kctrl,
    input  logic [31:0]           pcIf,
    input  logic [31:0]           pcId,
    input  logic [`WIDTH_EXC-1:0] excId,
    stageIf.ctrl                  stages,
    output logic                  stallPc,
    output logic                  stallId,
    output logic                  clrId,
    output logic                  clrEx,
    output logic                  clrMem,
    output logic                  clrWb,
    output logic                  disMultDiv,
    output logic                  disDm,
    output logic [31:0]           macroPc
);
    import instrPkg::*;
    import pipeCtrlPkg::*;

    logic stallRs;
    logic stallRt;
    logic stallMd;
    logic stall;
    logic flush;

    // operand not ready in time from either tracked stage
    function automatic logic srcHazard(
        input logic [`WIDTH_REG-1:0] addr,
        input logic [`WIDTH_T-1:0]   tuse,
        input stageRecT              exR,
        input stageRecT              memR
    );
        logic exHit;
        logic memHit;
        exHit  = (exR.destReg == addr) && (exR.tnew > tuse);
        memHit = (memR.destReg == addr) && (memR.tnew > tuse);
        return (addr != '0) && (exHit || memHit);   // $0 is always ready
    endfunction

    assign stallRs = srcHazard(addrRs, tuseRs, stages.exRec, stages.memRec);
    assign stallRt = srcHazard(addrRt, tuseRt, stages.exRec, stages.memRec);
    assign stallMd = mdBusy && (funcId == MULTDIV);
    assign stall   = stallRs || stallRt || stallMd;

    assign flush = (kctrl == KCTRL_KTEXT) || (kctrl == KCTRL_ERET);

    // redirect wins over any stall
    assign stallPc    = stall && !flush;
    assign stallId    = stall && !flush;
    assign clrEx      = stall || flush;   // bubble on stall, kill on flush
    assign clrId      = flush;
    assign clrMem     = flush;
    assign clrWb      = flush;
    assign disMultDiv = flush;
    assign disDm      = flush;

    // oldest stage holding something real
    always_comb begin
        if (stages.memRec.pc != '0 || stages.memRec.exc != '0) begin
            macroPc = stages.memRec.pc;
        end else if (stages.exRec.pc != '0 || stages.exRec.exc != '0) begin
            macroPc = stages.exRec.pc;
        end else if (pcId != '0 || excId != '0) begin
            macroPc = pcId;
        end else begin
            macroPc = pcIf;   // zero when IF is empty too
        end
    end

endmodule

`default_nettype wire

/* logic/stageTracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module stageTracker (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [`WIDTH_REG-1:0] destId,
    input  logic [`WIDTH_T-1:0]   tnewId,
    input  logic [31:0]           pcId,
    input  logic [`WIDTH_EXC-1:0] excId,
    input  logic                  clrEx,
    input  logic                  clrMem,
    stageIf.track                 stages
);
    import pipeCtrlPkg::*;

    stageRecT exNext;
    stageRecT memNext;

    // one stage closer to the result, never below zero
    function automatic logic [`WIDTH_T-1:0] ageT(input logic [`WIDTH_T-1:0] t);
        return (t == '0) ? '0 : t - 1'b1;
    endfunction

    always_comb begin
        if (clrEx) begin
            exNext = '0;   // bubble into EX
        end else begin
            exNext.destReg = destId;
            exNext.tnew    = ageT(tnewId);
            exNext.pc      = pcId;
            exNext.exc     = excId;
        end
    end

    always_comb begin
        if (clrMem) begin
            memNext = '0;
        end else begin
            memNext      = stages.exRec;
            memNext.tnew = ageT(stages.exRec.tnew);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stages.exRec  <= '0;
            stages.memRec <= '0;
        end else begin
            stages.exRec  <= exNext;
            stages.memRec <= memNext;
        end
    end

endmodule

`default_nettype wire

/* logic/tuseTnewTable.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module tuseTnewTable (
    input  instrPkg::opcodeT      opcode,
    input  instrPkg::funcT        func,
    output logic [`WIDTH_T-1:0]   tuseRs,
    output logic [`WIDTH_T-1:0]   tuseRt,
    output logic [`WIDTH_T-1:0]   tnewId
);
    import instrPkg::*;

    localparam logic [`WIDTH_T-1:0] T0   = 0;
    localparam logic [`WIDTH_T-1:0] T1   = 1;
    localparam logic [`WIDTH_T-1:0] T2   = 2;
    localparam logic [`WIDTH_T-1:0] T3   = 3;
    localparam logic [`WIDTH_T-1:0] TINF = `TUSE_INF;

    always_comb begin
        // nothing read, nothing produced unless listed below
        tuseRs = TINF;
        tuseRt = TINF;
        tnewId = T0;
        case (func)
            CALC_R: begin
                tuseRs = (opcode == OP_SLL) ? TINF : T1;  // shift takes shamt, not rs
                tuseRt = T1;
                tnewId = T2;
            end
            CALC_I: begin
                if (opcode == OP_LUI) begin
                    tnewId = T1;
                end else begin
                    tuseRs = T1;
                    tnewId = T2;
                end
            end
            MEM_READ: begin
                tuseRs = T1;   // address calc in EX
                tnewId = T3;
            end
            MEM_WRITE: begin
                tuseRs = T1;
                tuseRt = T2;   // store data only needed in MEM
            end
            BRANCH: begin
                tuseRs = T0;   // compared in ID
                tuseRt = T0;
            end
            JUMP: begin
                if (opcode == OP_JR) tuseRs = T0;
                if (opcode == OP_JAL) tnewId = T1;
            end
            MULTDIV: begin
                if (opcode == OP_MULT) begin
                    tuseRs = T1;
                    tuseRt = T1;
                end
                if (opcode == OP_MFLO) tnewId = T2;
            end
            CP0: begin
                if (opcode == OP_MTC0) tuseRt = T2;
                if (opcode == OP_MFC0) tnewId = T3;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/instrClassifier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module instrClassifier (
    input  logic [`WIDTH_INSTR-1:0] instr,
    output instrPkg::opcodeT        opcode,
    output instrPkg::funcT          func,
    output logic [`WIDTH_REG-1:0]   addrRs,
    output logic [`WIDTH_REG-1:0]   addrRt,
    output logic [`WIDTH_REG-1:0]   destReg
);
    import instrPkg::*;

    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_COP0    = 6'b010000;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_LUI     = 6'b001111;
    localparam logic [5:0] OPC_LW      = 6'b100011;
    localparam logic [5:0] OPC_SW      = 6'b101011;
    localparam logic [5:0] OPC_BEQ     = 6'b000100;
    localparam logic [5:0] OPC_JAL     = 6'b000011;
    localparam logic [5:0] FN_ADDU     = 6'b100001;
    localparam logic [5:0] FN_SUBU     = 6'b100011;
    localparam logic [5:0] FN_SLL      = 6'b000000;
    localparam logic [5:0] FN_JR       = 6'b001000;
    localparam logic [5:0] FN_MULT     = 6'b011000;
    localparam logic [5:0] FN_MFLO     = 6'b010010;
    localparam logic [5:0] FN_ERET     = 6'b011000;   // under COP0 with CO set
    localparam logic [4:0] CP0_MF      = 5'b00000;
    localparam logic [4:0] CP0_MT      = 5'b00100;
    localparam logic [4:0] CP0_CO      = 5'b10000;
    localparam logic [`WIDTH_REG-1:0] REG_RA = 31;   // link register for JAL

    logic [5:0] opField;
    logic [5:0] fnField;
    logic [4:0] rdField;

    assign opField = instr[31:26];
    assign fnField = instr[5:0];
    assign rdField = instr[15:11];
    assign addrRs  = instr[25:21];
    assign addrRt  = instr[20:16];

    always_comb begin
        opcode = OP_NOP;
        case (opField)
            OPC_SPECIAL: begin
                case (fnField)
                    FN_ADDU: opcode = OP_ADDU;
                    FN_SUBU: opcode = OP_SUBU;
                    FN_SLL:  if (instr != '0) opcode = OP_SLL;  // zero word stays NOP
                    FN_JR:   opcode = OP_JR;
                    FN_MULT: opcode = OP_MULT;
                    FN_MFLO: opcode = OP_MFLO;
                    default: ;
                endcase
            end
            OPC_COP0: begin
                if (addrRs == CP0_MT) opcode = OP_MTC0;
                else if (addrRs == CP0_MF) opcode = OP_MFC0;
                else if (addrRs == CP0_CO && fnField == FN_ERET) opcode = OP_ERET;
            end
            OPC_ORI: opcode = OP_ORI;
            OPC_LUI: opcode = OP_LUI;
            OPC_LW:  opcode = OP_LW;
            OPC_SW:  opcode = OP_SW;
            OPC_BEQ: opcode = OP_BEQ;
            OPC_JAL: opcode = OP_JAL;
            default: ;
        endcase
    end

    // class and written register follow from the opcode
    always_comb begin
        func    = NONE;
        destReg = '0;
        case (opcode)
            OP_ADDU, OP_SUBU, OP_SLL: begin
                func    = CALC_R;
                destReg = rdField;
            end
            OP_ORI, OP_LUI: begin
                func    = CALC_I;
                destReg = addrRt;
            end
            OP_LW: begin
                func    = MEM_READ;
                destReg = addrRt;
            end
            OP_SW:  func = MEM_WRITE;
            OP_BEQ: func = BRANCH;
            OP_JAL: begin
                func    = JUMP;
                destReg = REG_RA;
            end
            OP_JR:   func = JUMP;
            OP_MULT: func = MULTDIV;   // result goes to HI/LO, not a GPR
            OP_MFLO: begin
                func    = MULTDIV;
                destReg = rdField;
            end
            OP_MTC0, OP_ERET: func = CP0;
            OP_MFC0: begin
                func    = CP0;
                destReg = addrRt;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/stageIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface stageIf;
    import pipeCtrlPkg::*;

    stageRecT exRec;
    stageRecT memRec;

    // tracker owns the records
    modport track (
        output exRec,
        output memRec
    );

    // controller only looks at them
    modport ctrl (
        input exRec,
        input memRec
    );

endinterface

`default_nettype wire

/* logic/pipeCtrlPkg.sv */
`default_nettype none

`include "cpu_settings.svh"

package pipeCtrlPkg;

    // redirect request coming from CP0
    typedef enum logic [1:0] {
        KCTRL_NONE  = 2'd0,
        KCTRL_KTEXT = 2'd1,   // exception entry
        KCTRL_ERET  = 2'd2    // return from handler
    } kctrlT;

    // what we keep about an instruction sitting in EX or MEM
    typedef struct packed {
        logic [`WIDTH_REG-1:0] destReg;  // zero = writes nothing
        logic [`WIDTH_T-1:0]   tnew;     // cycles left until result ready
        logic [31:0]           pc;
        logic [`WIDTH_EXC-1:0] exc;
    } stageRecT;

endpackage

`default_nettype wire

/* logic/instrPkg.sv */
`default_nettype none

package instrPkg;

    // decoded instruction, one value per supported op
    typedef enum logic [3:0] {
        OP_NOP,     // all-zero word or anything unrecognized
        OP_ADDU,
        OP_SUBU,
        OP_SLL,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_JAL,
        OP_JR,
        OP_MULT,
        OP_MFLO,
        OP_MTC0,
        OP_MFC0,
        OP_ERET
    } opcodeT;

    // function class, drives the Tuse/Tnew lookup
    typedef enum logic [3:0] {
        CALC_R,
        CALC_I,
        MEM_READ,
        MEM_WRITE,
        BRANCH,
        JUMP,
        MULTDIV,
        CP0,
        NONE
    } funcT;

endpackage

`default_nettype wire

/* logic/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction word width
`define WIDTH_INSTR 32

// GPR address width
`define WIDTH_REG 5

// width of Tuse and Tnew counts
`define WIDTH_T 3

// Tuse for an operand that is never read, larger than any real Tnew
`define TUSE_INF 3'd7

// exception code width, zero = no exception
`define WIDTH_EXC 5

`endif
